/* source/blit_regs_pkg.sv */
package blit_regs_pkg;

    // blit register numbers, written one word at a time by the host
    typedef enum logic [3:0] {
        REG_CTRL  = 4'd0,           // control bits and transparency value
        REG_SHIFT = 4'd1,           // nibble shift and edge masks
        REG_MOD_A = 4'd2,
        REG_SRC_A = 4'd3,
        REG_MOD_B = 4'd4,
        REG_SRC_B = 4'd5,
        REG_MOD_C = 4'd6,
        REG_VAL_C = 4'd7,
        REG_MOD_D = 4'd8,
        REG_DST_D = 4'd9,
        REG_LINES = 4'd10,          // line count minus one
        REG_WORDS = 4'd11           // word count minus one, queues the blit
    } blit_reg_t;

    // REG_CTRL fields
    localparam int CTRL_A_CONST_BIT = 0;
    localparam int CTRL_B_CONST_BIT = 1;
    localparam int CTRL_B_NOT_BIT   = 2;
    localparam int CTRL_C_USE_B_BIT = 3;
    localparam int CTRL_TRANSP_LSB  = 8;    // 8 bits, two transparency nibbles

    // REG_SHIFT fields
    localparam int SHIFT_F_MASK_LSB = 12;
    localparam int SHIFT_L_MASK_LSB = 8;
    localparam int SHIFT_AMT_LSB    = 0;    // 2 bits

endpackage

/* source/blit_core_pkg.sv */
package blit_core_pkg;

    localparam int WORD_BITS     = 16;
    localparam int NIB_BITS      = 4;
    localparam int NIBS_PER_WORD = 4;

    typedef logic [WORD_BITS-1:0]     word_t;       // video memory data word
    typedef logic [WORD_BITS-1:0]     addr_t;       // video memory word address
    typedef logic [NIBS_PER_WORD-1:0] nib_mask_t;   // bit 3 is the high nibble
    typedef logic [1:0]               shift_t;      // right shift in nibbles

    // sequencer states
    typedef enum logic [2:0] {
        IDLE,                       // wait for a queued blit
        SETUP,                      // copy queued registers into the engine
        LINE_BEG,                   // load word counter, start first access
        RD_A,                       // read source A
        RD_B,                       // read source B
        WR_D,                       // write destination D
        LINE_END                    // apply modulos, next line or finish
    } blit_state_t;

endpackage

/* source/blit_reg_queue.sv */
`timescale 1ns/1ps

module blit_reg_queue (
    input  logic                      clk,
    input  logic                      reset_i,
    input  logic                      reg_wr_i,
    input  blit_regs_pkg::blit_reg_t  reg_num_i,
    input  blit_core_pkg::word_t      reg_data_i,
    input  logic                      setup_i,      // engine has copied the queued blit
    output logic                      queued_o,
    output logic                      a_const_o,
    output logic                      b_const_o,
    output logic                      b_not_o,
    output logic                      c_use_b_o,
    output logic [7:0]                transp_o,
    output blit_core_pkg::shift_t     shift_o,
    output blit_core_pkg::nib_mask_t  f_mask_o,
    output blit_core_pkg::nib_mask_t  l_mask_o,
    output blit_core_pkg::word_t      mod_a_o,
    output blit_core_pkg::word_t      src_a_o,
    output blit_core_pkg::word_t      mod_b_o,
    output blit_core_pkg::word_t      src_b_o,
    output blit_core_pkg::word_t      mod_c_o,
    output blit_core_pkg::word_t      val_c_o,
    output blit_core_pkg::word_t      mod_d_o,
    output blit_core_pkg::word_t      dst_d_o,
    output blit_core_pkg::word_t      lines_o,
    output blit_core_pkg::word_t      words_o
);
    import blit_regs_pkg::*;
    import blit_core_pkg::*;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            queued_o  <= 1'b0;
            a_const_o <= 1'b0;
            b_const_o <= 1'b0;
            b_not_o   <= 1'b0;
            c_use_b_o <= 1'b0;
        end else begin
            if (setup_i) begin
                queued_o <= 1'b0;                   // a WORDS write below wins
            end
            if (reg_wr_i && reg_num_i == REG_CTRL) begin
                a_const_o <= reg_data_i[CTRL_A_CONST_BIT];
                b_const_o <= reg_data_i[CTRL_B_CONST_BIT];
                b_not_o   <= reg_data_i[CTRL_B_NOT_BIT];
                c_use_b_o <= reg_data_i[CTRL_C_USE_B_BIT];
            end
            if (reg_wr_i && reg_num_i == REG_WORDS) begin
                queued_o <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reg_wr_i) begin
            case (reg_num_i)
                REG_CTRL:  transp_o <= reg_data_i[CTRL_TRANSP_LSB +: 8];
                REG_SHIFT: begin
                    shift_o  <= reg_data_i[SHIFT_AMT_LSB +: 2];
                    f_mask_o <= reg_data_i[SHIFT_F_MASK_LSB +: NIBS_PER_WORD];
                    l_mask_o <= reg_data_i[SHIFT_L_MASK_LSB +: NIBS_PER_WORD];
                end
                REG_MOD_A: mod_a_o <= reg_data_i;
                REG_SRC_A: src_a_o <= reg_data_i;
                REG_MOD_B: mod_b_o <= reg_data_i;
                REG_SRC_B: src_b_o <= reg_data_i;
                REG_MOD_C: mod_c_o <= reg_data_i;
                REG_VAL_C: val_c_o <= reg_data_i;
                REG_MOD_D: mod_d_o <= reg_data_i;
                REG_DST_D: dst_d_o <= reg_data_i;
                REG_LINES: lines_o <= reg_data_i;
                REG_WORDS: words_o <= reg_data_i;
                default: begin
                end
            endcase
        end
    end

endmodule

/* source/blit_source_channel.sv */
`timescale 1ns/1ps

module blit_source_channel (
    input  logic                   clk,
    input  logic                   reset_i,
    input  logic                   setup_i,
    input  logic                   load_i,          // memory word arrives
    input  logic                   line_end_i,
    input  blit_core_pkg::word_t   start_i,         // constant value at blit start
    input  blit_core_pkg::word_t   mod_i,
    input  blit_core_pkg::word_t   data_i,
    input  blit_core_pkg::shift_t  shift_i,
    output blit_core_pkg::word_t   val_o
);
    import blit_core_pkg::*;

    word_t  prev;                                   // raw previous memory word
    word_t  mod;
    shift_t shift;

    // low n nibbles of last become the top nibbles, then the top of cur
    function automatic word_t shift_right(shift_t n, word_t cur, word_t last);
        logic [2*WORD_BITS-1:0] both;
        both = {last, cur} >> (n * NIB_BITS);
        return both[WORD_BITS-1:0];
    endfunction

    always_ff @(posedge clk) begin
        if (reset_i) begin
            val_o <= '0;
            prev  <= '0;
        end else if (setup_i) begin
            val_o <= start_i;                       // used as is when constant
            prev  <= '0;
        end else if (load_i) begin
            val_o <= shift_right(shift, data_i, prev);
            prev  <= data_i;
        end else if (line_end_i) begin
            val_o <= val_o ^ mod;                   // only matters for a constant
        end
    end

    // per-blit settings, the queue may already hold the next blit
    always_ff @(posedge clk) begin
        if (setup_i) begin
            mod   <= mod_i;
            shift <= shift_i;
        end
    end

endmodule

/* source/blit_sequencer.sv */
`timescale 1ns/1ps

module blit_sequencer (
    input  logic                      clk,
    input  logic                      reset_i,
    input  logic                      queued_i,
    input  logic                      a_const_i,
    input  logic                      b_const_i,
    input  blit_core_pkg::nib_mask_t  f_mask_i,
    input  blit_core_pkg::nib_mask_t  l_mask_i,
    input  blit_core_pkg::word_t      src_a_i,
    input  blit_core_pkg::word_t      src_b_i,
    input  blit_core_pkg::word_t      dst_d_i,
    input  blit_core_pkg::word_t      mod_a_i,
    input  blit_core_pkg::word_t      mod_b_i,
    input  blit_core_pkg::word_t      mod_d_i,
    input  blit_core_pkg::word_t      lines_i,
    input  blit_core_pkg::word_t      words_i,
    input  logic                      vram_ack_i,
    output logic                      setup_o,
    output logic                      load_a_o,
    output logic                      load_b_o,
    output logic                      line_end_o,
    output logic                      busy_o,
    output logic                      done_intr_o,
    output logic                      vram_sel_o,
    output logic                      vram_wr_o,
    output blit_core_pkg::nib_mask_t  pos_mask_o,
    output blit_core_pkg::addr_t      vram_addr_o
);
    import blit_core_pkg::*;

    blit_state_t          state, state_next, first_access;
    logic                 advance;
    logic                 a_const, b_const;
    logic                 first_word;
    logic [WORD_BITS:0]   line_cnt;                 // msb set after last line
    logic [WORD_BITS:0]   word_cnt;                 // msb set on last word
    addr_t                addr_a, addr_b, addr_d;
    word_t                mod_a, mod_b, mod_d, words;
    nib_mask_t            f_mask, l_mask;

    assign vram_sel_o  = (state == RD_A) || (state == RD_B) || (state == WR_D);
    assign vram_wr_o   = (state == WR_D);
    assign vram_addr_o = (state == RD_A) ? addr_a : (state == RD_B) ? addr_b : addr_d;
    assign advance     = !vram_sel_o || vram_ack_i;     // hold while memory stalls

    assign setup_o    = (state == SETUP);
    assign load_a_o   = (state == RD_A) && vram_ack_i;
    assign load_b_o   = (state == RD_B) && vram_ack_i;
    assign line_end_o = (state == LINE_END) && advance;
    assign busy_o     = (state != IDLE);
    assign pos_mask_o = (first_word ? f_mask : '1) & (word_cnt[WORD_BITS] ? l_mask : '1);

    // skip reads of constant sources
    assign first_access = !a_const ? RD_A : !b_const ? RD_B : WR_D;

    always_comb begin
        case (state)
            IDLE:     state_next = queued_i ? SETUP : IDLE;
            SETUP:    state_next = LINE_BEG;
            LINE_BEG: state_next = first_access;
            RD_A:     state_next = b_const ? WR_D : RD_B;
            RD_B:     state_next = WR_D;
            WR_D:     state_next = word_cnt[WORD_BITS] ? LINE_END : first_access;
            LINE_END: begin
                if (!line_cnt[WORD_BITS]) begin
                    state_next = LINE_BEG;
                end else begin
                    state_next = queued_i ? SETUP : IDLE;   // next blit without idling
                end
            end
            default:  state_next = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state       <= IDLE;
            done_intr_o <= 1'b0;
        end else begin
            done_intr_o <= line_end_o && line_cnt[WORD_BITS];
            if (advance) begin
                state <= state_next;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            case (state)
                SETUP: begin
                    a_const  <= a_const_i;
                    b_const  <= b_const_i;
                    f_mask   <= f_mask_i;
                    l_mask   <= l_mask_i;
                    addr_a   <= src_a_i;
                    addr_b   <= src_b_i;
                    addr_d   <= dst_d_i;
                    mod_a    <= mod_a_i;
                    mod_b    <= mod_b_i;
                    mod_d    <= mod_d_i;
                    words    <= words_i;
                    line_cnt <= {1'b0, lines_i};
                end
                LINE_BEG: begin
                    line_cnt   <= line_cnt - 1'b1;
                    word_cnt   <= {1'b0, words} - 1'b1;
                    first_word <= 1'b1;
                end
                RD_A: addr_a <= addr_a + 1'b1;
                RD_B: addr_b <= addr_b + 1'b1;
                WR_D: begin
                    addr_d     <= addr_d + 1'b1;
                    word_cnt   <= word_cnt - 1'b1;
                    first_word <= 1'b0;
                end
                LINE_END: begin
                    addr_a <= addr_a + mod_a;
                    addr_b <= addr_b + mod_b;
                    addr_d <= addr_d + mod_d;
                end
                default: begin
                end
            endcase
        end
    end

endmodule

/* source/blit_write_unit.sv */
`timescale 1ns/1ps

module blit_write_unit (
    input  logic                      clk,
    input  logic                      reset_i,
    input  logic                      setup_i,
    input  logic                      line_end_i,
    input  logic                      b_not_i,
    input  logic                      c_use_b_i,
    input  logic [7:0]                transp_i,
    input  blit_core_pkg::word_t      val_a_i,
    input  blit_core_pkg::word_t      val_b_i,
    input  blit_core_pkg::word_t      val_c_i,
    input  blit_core_pkg::word_t      mod_c_i,
    input  blit_core_pkg::nib_mask_t  pos_mask_i,
    output blit_core_pkg::word_t      vram_data_o,
    output blit_core_pkg::nib_mask_t  vram_mask_o
);
    import blit_core_pkg::*;

    logic       b_not, c_use_b;
    logic [7:0] transp;
    word_t      c_reg, mod_c;
    word_t      b_op, c_op;
    nib_mask_t  opaque;                             // B nibble differs from transp

    always_ff @(posedge clk) begin
        if (reset_i) begin
            b_not   <= 1'b0;
            c_use_b <= 1'b0;
        end else if (setup_i) begin
            b_not   <= b_not_i;
            c_use_b <= c_use_b_i;
        end
    end

    always_ff @(posedge clk) begin
        if (setup_i) begin
            transp <= transp_i;
            mod_c  <= mod_c_i;
            c_reg  <= val_c_i;
        end else if (line_end_i) begin
            c_reg  <= c_reg ^ mod_c;
        end
    end

    assign b_op        = b_not ? ~val_b_i : val_b_i;
    assign c_op        = c_use_b ? val_b_i : c_reg;     // plain B, not inverted
    assign vram_data_o = (val_a_i & b_op) ^ c_op;

    // odd nibbles compare with the high transparency nibble
    always_comb begin
        for (int i = 0; i < NIBS_PER_WORD; i++) begin
            opaque[i] = val_b_i[i*NIB_BITS +: NIB_BITS] !=
                        ((i % 2 == 1) ? transp[7:4] : transp[3:0]);
        end
    end

    assign vram_mask_o = pos_mask_i & opaque;

endmodule

/* source/blitter_top.sv */
`timescale 1ns/1ps

module blitter_top (
    input  logic                      clk,
    input  logic                      reset_i,
    input  logic                      reg_wr_i,
    input  blit_regs_pkg::blit_reg_t  reg_num_i,
    input  blit_core_pkg::word_t      reg_data_i,
    output logic                      busy_o,
    output logic                      full_o,
    output logic                      done_intr_o,
    output logic                      vram_sel_o,
    input  logic                      vram_ack_i,
    output logic                      vram_wr_o,
    output blit_core_pkg::nib_mask_t  vram_mask_o,
    output blit_core_pkg::addr_t      vram_addr_o,
    input  blit_core_pkg::word_t      vram_data_i,
    output blit_core_pkg::word_t      vram_data_o
);
    import blit_core_pkg::*;

    logic       setup, load_a, load_b, line_end;
    logic       a_const, b_const, b_not, c_use_b;
    logic [7:0] transp;
    shift_t     shift;
    nib_mask_t  f_mask, l_mask, pos_mask;
    word_t      mod_a, src_a, mod_b, src_b, mod_c, val_c, mod_d, dst_d, lines, words;
    word_t      val_a, val_b;

    blit_reg_queue queue_i (
        .clk, .reset_i, .reg_wr_i, .reg_num_i, .reg_data_i,
        .setup_i(setup), .queued_o(full_o),
        .a_const_o(a_const), .b_const_o(b_const), .b_not_o(b_not), .c_use_b_o(c_use_b),
        .transp_o(transp), .shift_o(shift), .f_mask_o(f_mask), .l_mask_o(l_mask),
        .mod_a_o(mod_a), .src_a_o(src_a), .mod_b_o(mod_b), .src_b_o(src_b),
        .mod_c_o(mod_c), .val_c_o(val_c), .mod_d_o(mod_d), .dst_d_o(dst_d),
        .lines_o(lines), .words_o(words)
    );

    blit_source_channel chan_a (
        .clk, .reset_i, .setup_i(setup), .load_i(load_a), .line_end_i(line_end),
        .start_i(src_a), .mod_i(mod_a), .data_i(vram_data_i), .shift_i(shift),
        .val_o(val_a)
    );

    blit_source_channel chan_b (
        .clk, .reset_i, .setup_i(setup), .load_i(load_b), .line_end_i(line_end),
        .start_i(src_b), .mod_i(mod_b), .data_i(vram_data_i), .shift_i(shift),
        .val_o(val_b)
    );

    blit_sequencer seq_i (
        .clk, .reset_i, .queued_i(full_o), .a_const_i(a_const), .b_const_i(b_const),
        .f_mask_i(f_mask), .l_mask_i(l_mask),
        .src_a_i(src_a), .src_b_i(src_b), .dst_d_i(dst_d),
        .mod_a_i(mod_a), .mod_b_i(mod_b), .mod_d_i(mod_d),
        .lines_i(lines), .words_i(words), .vram_ack_i,
        .setup_o(setup), .load_a_o(load_a), .load_b_o(load_b), .line_end_o(line_end),
        .busy_o, .done_intr_o, .vram_sel_o, .vram_wr_o,
        .pos_mask_o(pos_mask), .vram_addr_o
    );

    blit_write_unit write_i (
        .clk, .reset_i, .setup_i(setup), .line_end_i(line_end),
        .b_not_i(b_not), .c_use_b_i(c_use_b), .transp_i(transp),
        .val_a_i(val_a), .val_b_i(val_b), .val_c_i(val_c), .mod_c_i(mod_c),
        .pos_mask_i(pos_mask), .vram_data_o, .vram_mask_o
    );

endmodule

/* verif/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
        forever #4 clk_o = ~clk_o;                  // 8 ns period
    end

endmodule

/* verif/blitter_tb.sv */
`timescale 1ns/1ps

module blitter_tb;
    import blit_regs_pkg::*;
    import blit_core_pkg::*;

    logic       clk;
    logic       reset_i    = 1'b1;
    logic       reg_wr_i   = 1'b0;
    blit_reg_t  reg_num_i  = REG_CTRL;
    word_t      reg_data_i = '0;
    logic       vram_ack_i = 1'b0;
    word_t      vram_data_i = '0;
    logic       busy_o, full_o, done_intr_o, vram_sel_o, vram_wr_o;
    nib_mask_t  vram_mask_o;
    addr_t      vram_addr_o;
    word_t      vram_data_o;

    word_t       mem [0:65535] = '{default: '0};
    logic        load_wr   = 1'b0;                  // preload port of the memory model
    addr_t       load_addr = '0;
    word_t       load_data = '0;
    int unsigned wait_cnt  = 0;
    int          done_cnt  = 0;
    int          exp_done  = 0;

    tb_clock_gen clock_gen_i (.clk_o(clk));

    blitter_top blitter_top_i (.*);

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("STATUS: FAIL");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_word(input addr_t a, input word_t exp);
        if (mem[a] !== exp) fail_run($sformatf("Mismatch at %0t: mem[%h] is %h, expected %h",
                                               $time, a, mem[a], exp));
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) fail_run($sformatf("Mismatch at %0t: %s is %b, expected %b",
                                            $time, name, got, exp));
    endtask

    task automatic preload(input addr_t a, input word_t d);
        @(posedge clk);
        load_wr   <= 1'b1;
        load_addr <= a;
        load_data <= d;
        @(posedge clk);
        load_wr   <= 1'b0;
    endtask

    task automatic write_reg(input logic [3:0] r, input word_t d);
        @(posedge clk);
        reg_wr_i   <= 1'b1;
        reg_num_i  <= blit_reg_t'(r);
        reg_data_i <= d;
        @(posedge clk);
        reg_wr_i   <= 1'b0;
        if (r == REG_WORDS) begin
            @(negedge clk);
            check_flag("full", full_o, 1'b1);       // queued on the write edge
            @(negedge clk);
            check_flag("busy", busy_o, 1'b1);       // engine picks it up a cycle later
        end
    endtask

    task automatic wait_done;
        int n;
        n = 0;
        exp_done++;
        while (done_cnt < exp_done && n < 20000) begin
            @(negedge clk);
            n++;
        end
        if (done_cnt < exp_done) fail_run("timeout while waiting for the done pulse");
        @(negedge clk);
        check_flag("single done pulse", done_cnt == exp_done, 1'b1);
    endtask

    task automatic wait_taken;
        int n;
        n = 0;
        while (!(busy_o && !full_o) && n < 20000) begin
            @(negedge clk);
            n++;
        end
        if (!(busy_o && !full_o)) fail_run("timeout while waiting for the engine to start");
    endtask

    // video memory, acks after 0 to 3 random cycles
    always @(posedge clk) begin : mem_model
        word_t merged;
        int    i;
        merged = mem[vram_addr_o];
        for (i = 0; i < NIBS_PER_WORD; i++) begin
            if (vram_mask_o[i]) begin
                merged[i*NIB_BITS +: NIB_BITS] = vram_data_o[i*NIB_BITS +: NIB_BITS];
            end
        end
        if (load_wr) mem[load_addr] <= load_data;
        if (reset_i || vram_ack_i || !vram_sel_o) begin
            vram_ack_i <= 1'b0;
            wait_cnt   <= $urandom % 4;
        end else if (wait_cnt != 0) begin
            wait_cnt <= wait_cnt - 1;
        end else begin
            vram_ack_i <= 1'b1;
            if (vram_wr_o) mem[vram_addr_o] <= merged;
            else vram_data_i <= mem[vram_addr_o];
        end
    end

    // done pulses seen by the clock edge
    always @(posedge clk) begin
        if (!reset_i && done_intr_o) done_cnt <= done_cnt + 1;
    end

    initial begin : main
        int          fd, n;
        string       tag;
        logic [15:0] a, d;
        void'($urandom(68));
        repeat (8) @(posedge clk);
        reset_i <= 1'b0;
        @(negedge clk);
        check_flag("busy", busy_o, 1'b0);
        check_flag("full", full_o, 1'b0);
        check_flag("done", done_intr_o, 1'b0);
        check_flag("vram_sel", vram_sel_o, 1'b0);
        check_flag("vram_wr", vram_wr_o, 1'b0);
        fd = $fopen("verif/blit_vectors.txt", "r");
        if (fd == 0) fail_run("could not open the vector file verif/blit_vectors.txt");
        while ($fscanf(fd, "%s", tag) == 1) begin
            if (tag == "#") begin
                n = $fgets(tag, fd);                // rest of a comment line
            end else if (tag == "M") begin
                n = $fscanf(fd, "%h %h", a, d);
                if (n != 2) fail_run("missing address or data after tag M");
                preload(a, d);
            end else if (tag == "W") begin
                n = $fscanf(fd, "%h %h", a, d);
                if (n != 2) fail_run("missing register or data after tag W");
                write_reg(a[3:0], d);
            end else if (tag == "E") begin
                n = $fscanf(fd, "%h %h", a, d);
                if (n != 2) fail_run("missing address or data after tag E");
                check_word(a, d);
            end else if (tag == "G") begin
                wait_done();
            end else if (tag == "Q") begin
                wait_taken();
            end else begin
                fail_run($sformatf("unknown tag %s in the vector file", tag));
            end
        end
        $fclose(fd);
        if (done_cnt == exp_done && !busy_o && !full_o) begin
            $display("STATUS: PASS");
            $finish;
        end else begin
            $display("STATUS: FAIL");
            $fatal(1, "engine still busy or extra done pulses at the end");
        end
    end

endmodule

/* verif/blit_vectors.txt */
# M addr data = preload memory, W reg data = register write, E addr data = expected word
# G = wait for one done pulse, Q = wait until the running blit has left the queue
# 2 lines x 3 words, D = A & B ^ C with modulos on A, D and C
M 0100 1234 M 0101 FFFF M 0102 F0F0 M 0104 0FF0 M 0105 5A5A M 0106 FFFF
M 0200 FFFF M 0201 1357 M 0202 FFFF M 0203 FFFF M 0204 FFFF M 0205 9999
W 0 EE00 W 1 FF00 W 2 0001 W 3 0100 W 4 0000 W 5 0200 W 6 1111 W 7 0F0F
W 8 0002 W 9 0300 W A 0001 W B 0002 G
E 0300 1D3B E 0301 1C58 E 0302 FFFF E 0303 0000 E 0305 11EE E 0306 4444 E 0307 8787
# notB with CuseB gives A & ~B ^ B
W 0 EE0C W 3 0105 W 5 0201 W 9 0310 W A 0000 W B 0001 G
E 0310 5B5F E 0311 FFFF
# shift 1 with first mask 0111 and last mask 1100, B constant
M 0400 1234 M 0401 5678 M 0402 9ABC M 0500 DDDD M 0501 DDDD M 0502 DDDD
W 0 EE02 W 1 7C01 W 3 0400 W 5 FFFF W 7 0000 W 9 0500 W B 0002 G
E 0500 D123 E 0501 4567 E 0502 89DD
# shift 3 with last mask 0011
M 0510 BBBB M 0511 BBBB
W 1 F303 W 9 0510 W B 0001 G
E 0510 0001 E 0511 BB45
# A and B constant fill, constants change per line
W 0 EE03 W 1 FF00 W 2 0F0F W 3 FF00 W 4 1111 W 5 1234 W 6 0000 W 7 0000
W 8 0000 W 9 0600 W A 0001 W B 0001 G
E 0600 1200 E 0601 1200 E 0602 0005 E 0603 0005
# transparency 5 for odd nibbles and A for even nibbles
M 0700 5A5A M 0701 5AA5 M 0800 7777 M 0801 7777
W 0 5A01 W 3 FFFF W 5 0700 W 9 0800 W A 0000 W B 0001 G
E 0800 7777 E 0801 77A5
# second blit queued while the first one runs
W 0 EE03 W 3 FFFF W 5 1111 W 2 0000 W 4 0000 W 9 0900 W A 0003 W B 0007 Q
W 9 0A00 W A 0000 W B 0001 G G
E 0900 1111 E 091F 1111 E 0A00 1111 E 0A01 1111 E 0A02 0000

/* all.f */
source/blit_regs_pkg.sv
source/blit_core_pkg.sv
source/blit_reg_queue.sv
source/blit_source_channel.sv
source/blit_sequencer.sv
source/blit_write_unit.sv
source/blitter_top.sv
verif/tb_clock_gen.sv
verif/blitter_tb.sv

/* Makefile */
TOOL  = verilator
FLAGS = --binary --timing -j 0
TOP   = blitter_tb
FLIST = all.f
LOG   = sim.log

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove build output and log"
	@echo "make help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) -o $(TOP)
	-./obj_dir/$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "STATUS: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
